// ==== design/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

	// geometry
	localparam int DATA_W  = 32;
	localparam int WORDS   = 4;
	localparam int WAYS    = 2;
	localparam int TAG_W   = 8;
	localparam int INDEX_W = 4;
	localparam int SETS    = 1 << INDEX_W;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [$clog2(WORDS)-1:0] word_off_t;

	// word address as seen by the requester
	typedef struct packed {
		tag_t      tag;
		index_t    index;
		word_off_t word_off;
	} cache_addr_t;

	// line address on the memory side
	typedef struct packed {
		tag_t   tag;
		index_t index;
	} line_addr_t;

	typedef data_t [WORDS-1:0] mem_line_t;
	typedef data_t [WAYS-1:0][WORDS-1:0] data_line_t;

	typedef struct packed {
		logic valid;
		logic dirty;
		tag_t tag;
	} way_flags_t;

	// lru names the way to replace next
	typedef struct packed {
		way_flags_t [WAYS-1:0] way;
		logic                  lru;
	} flag_line_t;

	typedef struct packed {
		cache_addr_t addr;
		data_t       wdata;
		logic        wr;
		logic        rd;
	} cache_req_t;

	typedef struct packed {
		line_addr_t addr;
		mem_line_t  wline;
		logic       wr;
		logic       rd;
	} mem_req_t;

endpackage

`default_nettype wire

// ==== design/request_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module request_capture (
	input  wire logic                 clk_50m,
	input  wire logic                 rst_n,
	input  cache_pkg::cache_addr_t    addr,
	input  cache_pkg::data_t          data_in,
	input  wire logic                 wr,
	input  wire logic                 rd,
	input  wire logic                 valid,
	input  wire logic                 finish,
	output cache_pkg::cache_req_t     req,
	output logic                      req_pending
);

	logic accept;

	// only one direction per request, and only when nothing is in flight
	assign accept = valid && (wr ^ rd) && !req_pending;

	always_ff @(posedge clk_50m, negedge rst_n) begin
		if (!rst_n) begin
			req_pending <= 1'b0;
		end else if (accept) begin
			req_pending <= 1'b1;
		end else if (finish) begin
			req_pending <= 1'b0;
		end
	end

	// request fields held for the whole transaction
	always_ff @(posedge clk_50m) begin
		if (accept) begin
			req.addr.tag      <= addr.tag;
			req.addr.index    <= addr.index;
			req.addr.word_off <= addr.word_off;
			req.wdata         <= data_in;
			req.wr            <= wr;
			req.rd            <= rd;
		end
	end

endmodule

`default_nettype wire

// ==== design/cache_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ram #(
	parameter type entry_t = logic [31:0],
	parameter int  DEPTH   = 16
) (
	input  wire logic             clk_50m,
	input  wire logic             rst_n,
	input  wire logic             rd_en,
	input  wire logic             wr_en,
	input  cache_pkg::index_t     index,
	input  entry_t                wdata,
	output entry_t                rdata
);

	entry_t mem [DEPTH];

	always_ff @(posedge clk_50m) begin
		if (wr_en) begin
			mem[index] <= wdata;
		end
	end

	// read register holds its value between reads
	always_ff @(posedge clk_50m, negedge rst_n) begin
		if (!rst_n) begin
			rdata <= '0;
		end else if (rd_en) begin
			rdata <= mem[index];
		end
	end

endmodule

`default_nettype wire

// ==== design/cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
	input  wire logic                 clk_50m,
	input  wire logic                 rst_n,

	input  cache_pkg::cache_req_t     req,
	input  wire logic                 req_pending,
	output logic                      finish,
	output cache_pkg::data_t          d_out,
	output logic                      done,

	output logic                      ram_rd_en,
	output cache_pkg::index_t         ram_index,
	output logic                      data_wr_en,
	output cache_pkg::data_line_t     data_wline,
	input  cache_pkg::data_line_t     data_rline,
	output logic                      flag_wr_en,
	output cache_pkg::flag_line_t     flag_wline,
	input  cache_pkg::flag_line_t     flag_rline,

	output logic                      mem_start,
	output cache_pkg::mem_req_t       mem_req,
	input  wire logic                 mem_finish,
	input  cache_pkg::mem_line_t      fill_line
);

	typedef enum logic [2:0] {
		IDLE,
		READ,
		CHECK,
		EVICT,
		FILL,
		FINISH
	} ctrl_state_t;

	ctrl_state_t state, next_state;

	// one bit per set, set once the set has been written
	logic [cache_pkg::SETS-1:0] set_init;

	cache_pkg::flag_line_t flags_eff;
	cache_pkg::flag_line_t flags_new;
	cache_pkg::data_line_t merged;
	cache_pkg::data_t      rd_word;

	logic hit0;
	logic hit1;
	logic hit;
	logic victim;
	logic victim_dirty;
	logic way_sel;

	// way in use and whether a fill replaced it
	logic way_q;
	logic miss_q;

	assign ram_index = req.addr.index;

	// unwritten sets look empty whatever the ram holds
	assign flags_eff = set_init[req.addr.index] ? flag_rline : '0;

	assign hit0 = flags_eff.way[0].valid && (flags_eff.way[0].tag == req.addr.tag);
	assign hit1 = flags_eff.way[1].valid && (flags_eff.way[1].tag == req.addr.tag);
	assign hit  = hit0 || hit1;

	assign victim       = flags_eff.lru;
	assign victim_dirty = flags_eff.way[victim].valid && flags_eff.way[victim].dirty;
	assign way_sel      = hit ? hit1 : victim;

	always_ff @(posedge clk_50m, negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_ff @(posedge clk_50m, negedge rst_n) begin
		if (!rst_n) begin
			way_q  <= 1'b0;
			miss_q <= 1'b0;
		end else if (state == CHECK) begin
			way_q  <= way_sel;
			miss_q <= !hit;
		end
	end

	always_ff @(posedge clk_50m, negedge rst_n) begin
		if (!rst_n) begin
			set_init <= '0;
		end else if (state == FINISH) begin
			set_init[req.addr.index] <= 1'b1;
		end
	end

	// next state and memory requests
	always_comb begin
		next_state          = state;
		ram_rd_en           = 1'b0;
		mem_start           = 1'b0;
		mem_req             = '0;
		mem_req.addr.tag    = req.addr.tag;
		mem_req.addr.index  = req.addr.index;

		case (state)
			IDLE: begin
				if (req_pending) begin
					next_state = READ;
				end
			end
			READ: begin
				ram_rd_en  = 1'b1;
				next_state = CHECK;
			end
			CHECK: begin
				if (hit) begin
					next_state = FINISH;
				end else if (victim_dirty) begin
					// write back the old line first
					mem_start        = 1'b1;
					mem_req.addr.tag = flags_eff.way[victim].tag;
					mem_req.wline    = data_rline[victim];
					mem_req.wr       = 1'b1;
					next_state       = EVICT;
				end else begin
					mem_start  = 1'b1;
					mem_req.rd = 1'b1;
					next_state = FILL;
				end
			end
			EVICT: begin
				if (mem_finish) begin
					mem_start  = 1'b1;
					mem_req.rd = 1'b1;
					next_state = FILL;
				end
			end
			FILL: begin
				if (mem_finish) begin
					next_state = FINISH;
				end
			end
			FINISH: begin
				next_state = IDLE;
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	// line merge and flag update for the finishing access
	always_comb begin
		merged = data_rline;
		if (miss_q) begin
			merged[way_q] = fill_line;
		end
		rd_word = merged[way_q][req.addr.word_off];
		if (req.wr) begin
			merged[way_q][req.addr.word_off] = req.wdata;
		end

		flags_new                  = flags_eff;
		flags_new.way[way_q].valid = 1'b1;
		flags_new.way[way_q].tag   = req.addr.tag;
		if (miss_q) begin
			// freshly filled line is clean unless this access writes it
			flags_new.way[way_q].dirty = req.wr;
		end else begin
			flags_new.way[way_q].dirty = flags_eff.way[way_q].dirty || req.wr;
		end
		flags_new.lru = !way_q;
	end

	assign data_wline = merged;
	assign flag_wline = flags_new;

	// data ram only changes on a write or a fill
	assign data_wr_en = (state == FINISH) && (req.wr || miss_q);
	assign flag_wr_en = (state == FINISH);

	assign finish = (state == FINISH);
	assign done   = (state == FINISH);
	assign d_out  = ((state == FINISH) && req.rd) ? rd_word : '0;

endmodule

`default_nettype wire

// ==== design/line_mem_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_mem_port (
	input  wire logic                 clk_50m,
	input  wire logic                 rst_n,

	input  wire logic                 mem_start,
	input  cache_pkg::mem_req_t       mem_req,
	output logic                      mem_finish,
	output cache_pkg::mem_line_t      fill_line,

	output logic                      mem_wr,
	output logic                      mem_rd,
	output cache_pkg::line_addr_t     mem_addr,
	output cache_pkg::mem_line_t      mem_wline,
	input  cache_pkg::mem_line_t      mem_rline,
	input  wire logic                 mem_done
);

	logic busy;
	logic finish_q;

	assign busy = mem_wr || mem_rd;

	// strobes stay up until memory answers
	always_ff @(posedge clk_50m, negedge rst_n) begin
		if (!rst_n) begin
			mem_wr   <= 1'b0;
			mem_rd   <= 1'b0;
			finish_q <= 1'b0;
		end else begin
			finish_q <= busy && mem_done;
			if (mem_start) begin
				mem_wr <= mem_req.wr;
				mem_rd <= mem_req.rd;
			end else if (mem_done) begin
				mem_wr <= 1'b0;
				mem_rd <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_50m) begin
		if (mem_start) begin
			mem_addr  <= mem_req.addr;
			mem_wline <= mem_req.wline;
		end
	end

	// returned line held until the next fill
	always_ff @(posedge clk_50m) begin
		if (mem_rd && mem_done) begin
			fill_line <= mem_rline;
		end
	end

	assign mem_finish = finish_q;

endmodule

`default_nettype wire

// ==== design/cache_mem_sys.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_mem_sys (
	input  wire logic                 clk_50m,
	input  wire logic                 rst_n,

	input  cache_pkg::cache_addr_t    addr,
	input  cache_pkg::data_t          data_in,
	input  wire logic                 wr,
	input  wire logic                 rd,
	input  wire logic                 valid,
	output cache_pkg::data_t          d_out,
	output logic                      done,

	output logic                      mem_wr,
	output logic                      mem_rd,
	output cache_pkg::line_addr_t     mem_addr,
	output cache_pkg::mem_line_t      mem_wline,
	input  cache_pkg::mem_line_t      mem_rline,
	input  wire logic                 mem_done
);

	cache_pkg::cache_req_t req;
	logic                  req_pending;
	logic                  finish;

	logic                  ram_rd_en;
	cache_pkg::index_t     ram_index;
	logic                  data_wr_en;
	cache_pkg::data_line_t data_wline;
	cache_pkg::data_line_t data_rline;
	logic                  flag_wr_en;
	cache_pkg::flag_line_t flag_wline;
	cache_pkg::flag_line_t flag_rline;

	logic                  mem_start;
	cache_pkg::mem_req_t   mem_req;
	logic                  mem_finish;
	cache_pkg::mem_line_t  fill_line;

	request_capture capture_i (
		.clk_50m     (clk_50m),
		.rst_n       (rst_n),
		.addr        (addr),
		.data_in     (data_in),
		.wr          (wr),
		.rd          (rd),
		.valid       (valid),
		.finish      (finish),
		.req         (req),
		.req_pending (req_pending)
	);

	cache_ctrl ctrl_i (
		.clk_50m     (clk_50m),
		.rst_n       (rst_n),
		.req         (req),
		.req_pending (req_pending),
		.finish      (finish),
		.d_out       (d_out),
		.done        (done),
		.ram_rd_en   (ram_rd_en),
		.ram_index   (ram_index),
		.data_wr_en  (data_wr_en),
		.data_wline  (data_wline),
		.data_rline  (data_rline),
		.flag_wr_en  (flag_wr_en),
		.flag_wline  (flag_wline),
		.flag_rline  (flag_rline),
		.mem_start   (mem_start),
		.mem_req     (mem_req),
		.mem_finish  (mem_finish),
		.fill_line   (fill_line)
	);

	cache_ram #(
		.entry_t (cache_pkg::data_line_t),
		.DEPTH   (cache_pkg::SETS)
	) data_ram_i (
		.clk_50m (clk_50m),
		.rst_n   (rst_n),
		.rd_en   (ram_rd_en),
		.wr_en   (data_wr_en),
		.index   (ram_index),
		.wdata   (data_wline),
		.rdata   (data_rline)
	);

	cache_ram #(
		.entry_t (cache_pkg::flag_line_t),
		.DEPTH   (cache_pkg::SETS)
	) flag_ram_i (
		.clk_50m (clk_50m),
		.rst_n   (rst_n),
		.rd_en   (ram_rd_en),
		.wr_en   (flag_wr_en),
		.index   (ram_index),
		.wdata   (flag_wline),
		.rdata   (flag_rline)
	);

	line_mem_port mem_port_i (
		.clk_50m    (clk_50m),
		.rst_n      (rst_n),
		.mem_start  (mem_start),
		.mem_req    (mem_req),
		.mem_finish (mem_finish),
		.fill_line  (fill_line),
		.mem_wr     (mem_wr),
		.mem_rd     (mem_rd),
		.mem_addr   (mem_addr),
		.mem_wline  (mem_wline),
		.mem_rline  (mem_rline),
		.mem_done   (mem_done)
	);

endmodule

`default_nettype wire

// ==== tests/cache_mem_sys_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_mem_sys_assertions (
	input wire logic                  clk_50m,
	input wire logic                  rst_n,
	input wire logic                  done,
	input wire logic                  mem_wr,
	input wire logic                  mem_rd,
	input wire cache_pkg::line_addr_t mem_addr,
	input wire cache_pkg::mem_line_t  mem_wline,
	input wire logic                  mem_done
);

	done_pulse: assert property (@(posedge clk_50m) disable iff (!rst_n) done |=> !done)
		else $error("done stayed high for more than one cycle");

	one_strobe: assert property (@(posedge clk_50m) disable iff (!rst_n) !(mem_wr && mem_rd))
		else $error("mem_wr and mem_rd high together");

	// held strobe keeps its address and line
	strobe_hold: assert property (@(posedge clk_50m) disable iff (!rst_n)
		(mem_wr || mem_rd) && !mem_done |=>
		(mem_wr || mem_rd) && $stable(mem_addr) && $stable(mem_wline))
		else $error("memory strobe, address or line changed before mem_done");

endmodule

bind cache_mem_sys cache_mem_sys_assertions assertions_i (
	.clk_50m   (clk_50m),
	.rst_n     (rst_n),
	.done      (done),
	.mem_wr    (mem_wr),
	.mem_rd    (mem_rd),
	.mem_addr  (mem_addr),
	.mem_wline (mem_wline),
	.mem_done  (mem_done)
);

`default_nettype wire

// ==== tests/tb_cache_mem_sys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cache_mem_sys;

	localparam int ACCESSES = 800;
	localparam int TIMEOUT = 400;
	localparam cache_pkg::tag_t TAGS [3] = '{8'h00, 8'h5B, 8'hC7};

	logic                   clk_50m;
	logic                   rst_n;
	cache_pkg::cache_addr_t addr;
	cache_pkg::data_t       data_in;
	logic                   wr;
	logic                   rd;
	logic                   valid;
	cache_pkg::data_t       d_out;
	logic                   done;
	logic                   mem_wr;
	logic                   mem_rd;
	cache_pkg::line_addr_t  mem_addr;
	cache_pkg::mem_line_t   mem_wline;
	cache_pkg::mem_line_t   mem_rline;
	logic                   mem_done;

	logic [15:0] lfsr_state;

	// reference model
	cache_pkg::data_t word_store [logic [13:0]];
	logic             model_valid [cache_pkg::SETS][2];
	logic             model_dirty [cache_pkg::SETS][2];
	cache_pkg::tag_t  model_tag [cache_pkg::SETS][2];
	logic             model_lru [cache_pkg::SETS];

	// backing memory by line address
	cache_pkg::mem_line_t mem_store [logic [11:0]];

	cache_mem_sys dut_i (
		.clk_50m   (clk_50m),
		.rst_n     (rst_n),
		.addr      (addr),
		.data_in   (data_in),
		.wr        (wr),
		.rd        (rd),
		.valid     (valid),
		.d_out     (d_out),
		.done      (done),
		.mem_wr    (mem_wr),
		.mem_rd    (mem_rd),
		.mem_addr  (mem_addr),
		.mem_wline (mem_wline),
		.mem_rline (mem_rline),
		.mem_done  (mem_done)
	);

	initial begin
		clk_50m = 1'b0;
		forever #10 clk_50m = ~clk_50m;
	end

	// x16 + x14 + x13 + x11
	function automatic logic next_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			r = {r[30:0], next_bit()};
		end
		return r;
	endfunction

	function automatic cache_pkg::data_t init_word(input logic [13:0] wa);
		return 32'(wa) ^ 32'h5A5A0000;
	endfunction

	function automatic cache_pkg::data_t model_word(input logic [13:0] wa);
		if (word_store.exists(wa)) begin
			return word_store[wa];
		end
		return init_word(wa);
	endfunction

	function automatic cache_pkg::mem_line_t model_line(input logic [11:0] la);
		cache_pkg::mem_line_t line;
		for (int w = 0; w < 4; w++) begin
			line[w] = model_word({la, 2'(w)});
		end
		return line;
	endfunction

	function automatic cache_pkg::mem_line_t stored_line(input logic [11:0] la);
		cache_pkg::mem_line_t line;
		if (mem_store.exists(la)) begin
			return mem_store[la];
		end
		for (int w = 0; w < 4; w++) begin
			line[w] = init_word({la, 2'(w)});
		end
		return line;
	endfunction

	task automatic stop_on_error();
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
			stop_on_error();
		end
	endtask

	// memory side answers each strobe after 1 to 8 cycles
	initial begin
		logic [11:0] key;
		logic        is_wr;
		int          delay;
		mem_done  = 1'b0;
		mem_rline = '0;
		forever begin
			@(negedge clk_50m);
			if (rst_n && (mem_wr || mem_rd)) begin
				key   = {mem_addr.tag, mem_addr.index};
				is_wr = mem_wr;
				if (is_wr) begin
					mem_store[key] = mem_wline;
				end
				delay = 1 + int'(rand_bits(3));
				repeat (delay) @(posedge clk_50m);
				mem_done  <= 1'b1;
				mem_rline <= is_wr ? '0 : stored_line(key);
				@(posedge clk_50m);
				mem_done <= 1'b0;
			end
		end
	end

	task automatic run_access(input int n, input cache_pkg::cache_addr_t a, input logic is_wr,
			input cache_pkg::data_t wd);
		cache_pkg::index_t set;
		logic              hit;
		logic              way;
		logic              exp_evict;
		logic              busy_prev;
		logic              finished;
		logic [11:0]       victim_key;
		logic [11:0]       req_key;
		cache_pkg::data_t  exp_word;
		int                strobes;
		int                cycles;

		set     = a.index;
		req_key = {a.tag, a.index};
		hit     = 1'b0;
		way     = model_lru[set];
		for (int w = 0; w < 2; w++) begin
			if (model_valid[set][w] && model_tag[set][w] == a.tag) begin
				hit = 1'b1;
				way = 1'(w);
			end
		end
		exp_evict  = !hit && model_valid[set][way] && model_dirty[set][way];
		victim_key = {model_tag[set][way], set};
		exp_word   = model_word(a);

		@(posedge clk_50m);
		addr    <= a;
		data_in <= wd;
		wr      <= is_wr;
		rd      <= !is_wr;
		valid   <= 1'b1;

		strobes   = 0;
		cycles    = 0;
		busy_prev = 1'b0;
		finished  = 1'b0;
		while (!finished) begin
			@(negedge clk_50m);
			cycles++;
			if (cycles > TIMEOUT) begin
				$display("timeout: access %0d got no done within %0d cycles", n, TIMEOUT);
				stop_on_error();
			end
			if ((mem_wr || mem_rd) && !busy_prev) begin
				strobes++;
				if (exp_evict && strobes == 1) begin
					check_value($sformatf("write-back strobe, access %0d", n),
						128'(1), 128'(mem_wr));
					check_value($sformatf("write-back address, access %0d", n),
						128'(victim_key), 128'({mem_addr.tag, mem_addr.index}));
					check_value($sformatf("write-back line, access %0d", n),
						128'(model_line(victim_key)), 128'(mem_wline));
				end else begin
					check_value($sformatf("fill strobe, access %0d", n),
						128'(1), 128'(mem_rd));
					check_value($sformatf("fill address, access %0d", n),
						128'(req_key), 128'({mem_addr.tag, mem_addr.index}));
				end
			end
			if (!done) begin
				check_value($sformatf("d_out outside done, access %0d", n),
					128'(0), 128'(d_out));
			end
			busy_prev = mem_wr || mem_rd;
			finished  = done;
		end

		check_value($sformatf("memory strobes, access %0d", n),
			128'(hit ? 0 : (exp_evict ? 2 : 1)), 128'(strobes));
		// first negedge comes before the accepting edge
		if (hit) begin
			check_value($sformatf("hit latency, access %0d", n), 128'(3), 128'(cycles - 2));
		end
		if (is_wr) begin
			check_value($sformatf("d_out on write, access %0d", n), 128'(0), 128'(d_out));
		end else begin
			check_value($sformatf("read data, access %0d", n), 128'(exp_word), 128'(d_out));
		end

		if (is_wr) begin
			word_store[a] = wd;
		end
		model_dirty[set][way] = hit ? (model_dirty[set][way] || is_wr) : is_wr;
		model_valid[set][way] = 1'b1;
		model_tag[set][way]   = a.tag;
		model_lru[set]        = !way;

		@(posedge clk_50m);
		valid <= 1'b0;
		wr    <= 1'b0;
		rd    <= 1'b0;
	endtask

	initial begin
		cache_pkg::cache_addr_t a;
		cache_pkg::data_t       wd;
		logic                   is_wr;
		int                     sel;

		rst_n      = 1'b0;
		addr       = '0;
		data_in    = '0;
		wr         = 1'b0;
		rd         = 1'b0;
		valid      = 1'b0;
		lfsr_state = 16'd58352;
		for (int s = 0; s < cache_pkg::SETS; s++) begin
			model_lru[s] = 1'b0;
			for (int w = 0; w < 2; w++) begin
				model_valid[s][w] = 1'b0;
				model_dirty[s][w] = 1'b0;
				model_tag[s][w]   = '0;
			end
		end

		repeat (10) @(posedge clk_50m);
		rst_n <= 1'b1;
		@(negedge clk_50m);
		check_value("done after reset", 128'(0), 128'(done));
		check_value("mem_wr after reset", 128'(0), 128'(mem_wr));
		check_value("mem_rd after reset", 128'(0), 128'(mem_rd));
		@(posedge clk_50m);

		// three tags keep the sets under conflict
		for (int i = 0; i < ACCESSES; i++) begin
			sel        = int'(rand_bits(2) % 3);
			a.tag      = TAGS[sel];
			a.index    = 4'(rand_bits(4));
			a.word_off = 2'(rand_bits(2));
			is_wr      = 1'(rand_bits(1));
			wd         = rand_bits(32);
			run_access(i, a, is_wr, wd);
		end

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== cache_mem_sys.f ====
design/cache_pkg.sv
design/request_capture.sv
design/cache_ram.sv
design/cache_ctrl.sv
design/line_mem_port.sv
design/cache_mem_sys.sv
tests/cache_mem_sys_assertions.sv
tests/tb_cache_mem_sys.sv

// ==== Makefile ====
TOP = tb_cache_mem_sys

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): cache_mem_sys.f design/*.sv tests/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f cache_mem_sys.f

lint:
	verilator --lint-only -Wall --timescale 1ns/1ps --top-module cache_mem_sys \
		design/cache_pkg.sv design/request_capture.sv design/cache_ram.sv \
		design/cache_ctrl.sv design/line_mem_port.sv design/cache_mem_sys.sv

clean:
	rm -rf obj_dir
